/* tb.f */
+incdir+verif
src/nib_cpu_pkg.sv
src/fetch_unit.sv
src/instr_queue.sv
src/exec_unit.sv
src/nib_cpu_top.sv
verif/nib_cpu_tb.sv

/* verif/nib_cpu_model.svh */
`ifndef NIB_CPU_MODEL_SVH
`define NIB_CPU_MODEL_SVH

// Architectural state the expected results are computed from
typedef struct packed {
  logic [RAM_WORDS-1:0][NIB_W-1:0] ram;
  logic [NIB_W-1:0]                sp;
  logic                            carry;
  logic                            zero;
} model_t;

function automatic instr_u enc_mem(logic [7:0] op, logic [NIB_W-1:0] addr);
  instr_u w;
  w.mem.op   = op;
  w.mem.addr = addr;
  return w;
endfunction

function automatic instr_u enc_sti(logic [NIB_W-1:0] addr, logic [NIB_W-1:0] data);
  instr_u w;
  w.imm.op   = OP_STI;
  w.imm.addr = addr;
  w.imm.data = data;
  return w;
endfunction

function automatic instr_u enc_word(logic [11:0] value);
  instr_u w;
  w = value; // Whole-word opcodes such as the SP forms and NOP
  return w;
endfunction

// Expected retire report of one instruction, starting from state m
function automatic retire_t model_step(model_t m, logic [PC_W-1:0] pc, instr_u w);
  retire_t          r;
  logic [NIB_W-1:0] v;
  r       = '0;
  r.pc    = pc;
  r.sp    = m.sp;
  r.carry = m.carry;
  r.zero  = m.zero;
  if (w.mem.op == OP_INC_M || w.mem.op == OP_DEC_M) begin
    v          = m.ram[w.mem.addr];
    r.ram_we   = 1'b1;
    r.ram_addr = w.mem.addr;
    if (w.mem.op == OP_INC_M) begin
      r.ram_data = v + 4'd1;
      r.carry    = (v == 4'hF); // Carry out of F
    end else begin
      r.ram_data = v - 4'd1;
      r.carry    = (v == 4'h0); // Borrow out of 0
    end
    r.zero = (r.ram_data == 4'h0);
  end else if (w == OP_INC_SP) begin
    r.sp = m.sp + 4'd1;
  end else if (w == OP_DEC_SP) begin
    r.sp = m.sp - 4'd1;
  end else if (w.imm.op == OP_STI) begin
    r.ram_we   = 1'b1;
    r.ram_addr = w.imm.addr;
    r.ram_data = w.imm.data;
  end
  return r;
endfunction

// The retire report carries everything needed to advance the model
function automatic model_t model_apply(model_t m, retire_t r);
  if (r.ram_we) begin
    m.ram[r.ram_addr] = r.ram_data;
  end
  m.sp    = r.sp;
  m.carry = r.carry;
  m.zero  = r.zero;
  return m;
endfunction

`endif

/* verif/nib_cpu_tb.sv */
`default_nettype none

module nib_cpu_tb import nib_cpu_pkg::*; ();

  `include "nib_cpu_model.svh"

  localparam int LEN_SP   = 43;
  localparam int LEN_INC  = 32;
  localparam int LEN_DEC  = 32;
  localparam int LEN_RAND = 200;

  logic            clk;
  logic            rst_n;
  logic            prog_we;
  logic [PC_W-1:0] prog_addr;
  instr_u          prog_data;
  logic [PC_W-1:0] prog_len;
  logic            retire;
  retire_t         retire_state;
  logic            done;

  instr_u  prog [PROG_WORDS];
  retire_t exp_q [$];
  retire_t exp_head;
  model_t  model;
  string   test_name;
  logic    running = 1'b0;
  integer  seed = 37;

  nib_cpu_top #(.QUEUE_DEPTH(4)) u_nib_cpu_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .prog_len     (prog_len),
    .retire       (retire),
    .retire_state (retire_state),
    .done         (done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Long programs need a longer reset, one load cycle per word
  function automatic int reset_cycles(int len);
    return (len + 1 > 16) ? len + 1 : 16;
  endfunction

  function automatic int run_budget(int len);
    return reset_cycles(len) + 4 * len + 8;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("error %s expected %h actual %h", test, expected, actual));
    end
  endtask

  task automatic build_sp_program();
    prog[0] = enc_word(OP_DEC_SP); // First retire shows the reset state
    prog[1] = enc_sti(4'h0, 4'hF);
    prog[2] = enc_mem(OP_INC_M, 4'h0); // Sets carry and zero before the SP run
    for (int i = 3; i < 23; i++) begin
      prog[i] = enc_word(OP_INC_SP);
    end
    for (int i = 23; i < LEN_SP; i++) begin
      prog[i] = enc_word(OP_DEC_SP);
    end
  endtask

  task automatic build_mem_program(input logic [7:0] op, input logic [3:0] seed_offset);
    for (int a = 0; a < RAM_WORDS; a++) begin
      prog[a]             = enc_sti(a[3:0], a[3:0] + seed_offset);
      prog[RAM_WORDS + a] = enc_mem(op, a[3:0]);
    end
  endtask

  task automatic build_random_program();
    int         kind;
    logic [3:0] a;
    logic [3:0] d;
    for (int i = 0; i < LEN_RAND; i++) begin
      kind = $random(seed) & 15;
      a    = $random(seed);
      d    = $random(seed);
      if (kind < 5)       prog[i] = enc_mem(OP_INC_M, a);
      else if (kind < 10) prog[i] = enc_mem(OP_DEC_M, a);
      else if (kind < 12) prog[i] = enc_sti(a, d);
      else if (kind == 12) prog[i] = enc_word(OP_INC_SP);
      else if (kind == 13) prog[i] = enc_word(OP_DEC_SP);
      else                prog[i] = enc_word({4'h0, a, d}); // Falls through decode as NOP
    end
  endtask

  task automatic run_program(input string name, input int len);
    retire_t r;
    test_name = name;
    model     = '0;
    exp_q.delete();
    for (int i = 0; i < len; i++) begin
      r = model_step(model, i[PC_W-1:0], prog[i]);
      exp_q.push_back(r);
      model = model_apply(model, r);
    end
    @(posedge clk);
    #2 rst_n = 1'b0;
    prog_len = len[PC_W-1:0];
    // The last word lands on the edge that still sees reset low
    for (int i = 0; i < reset_cycles(len) - 1; i++) begin
      @(posedge clk);
      #2 prog_we = (i < len);
      prog_addr = i[PC_W-1:0];
      prog_data = prog[i];
    end
    @(posedge clk);
    #2 rst_n = 1'b1;
    prog_we = 1'b0;
    running = 1'b1;
    wait (!running);
    for (int a = 0; a < RAM_WORDS; a++) begin
      check_value($sformatf("%s_ram%0d", name, a), model.ram[a],
                  u_nib_cpu_top.u_exec_unit.ram_q[a]);
    end
    check_value({name, "_final"}, {model.sp, model.carry, model.zero},
                {u_nib_cpu_top.u_exec_unit.sp_q, u_nib_cpu_top.u_exec_unit.carry_q,
                 u_nib_cpu_top.u_exec_unit.zero_q});
  endtask

  // Outputs are sampled mid-cycle where they are settled
  always @(negedge clk) begin
    if (rst_n && running) begin
      if (retire) begin
        if (exp_q.size() == 0) begin
          stop_with_failure($sformatf("%s retired more instructions than the program has",
                                      test_name));
        end else begin
          exp_head = exp_q.pop_front();
          check_value(test_name, exp_head, retire_state);
        end
      end
      if (done) begin
        check_value({test_name, "_left"}, 0, exp_q.size()); // Done only after the last retire
        running = 1'b0;
      end
    end
  end

  initial begin
    repeat (run_budget(LEN_SP) + run_budget(LEN_INC) + run_budget(LEN_DEC)
            + run_budget(LEN_RAND) + 16) @(posedge clk);
    stop_with_failure("watchdog expired, the core never finished its programs");
  end

  initial begin
    rst_n     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    prog_len  = '0;
    build_sp_program();
    run_program("sp_wrap", LEN_SP);
    build_mem_program(OP_INC_M, 4'd2);
    run_program("inc_mem", LEN_INC);
    build_mem_program(OP_DEC_M, 4'd0); // Address 0 borrows, address 1 reaches zero
    run_program("dec_mem", LEN_DEC);
    build_random_program();
    run_program("random_backpressure", LEN_RAND);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src/nib_cpu_top.sv */
`default_nettype none

module nib_cpu_top import nib_cpu_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            prog_we,
  input  logic [PC_W-1:0] prog_addr,
  input  instr_u          prog_data,
  input  logic [PC_W-1:0] prog_len,
  output logic            retire,
  output retire_t         retire_state,
  output logic            done
);

  logic     push;
  logic     pop;
  logic     full;
  logic     empty;
  logic     issued_all;
  logic     exec_idle;
  fetched_t fetched;
  fetched_t head;

  fetch_unit u_fetch_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .prog_len   (prog_len),
    .full       (full),
    .push       (push),
    .fetched    (fetched),
    .issued_all (issued_all)
  );

  instr_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_instr_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (push),
    .wr_item (fetched),
    .pop     (pop),
    .rd_item (head),
    .full    (full),
    .empty   (empty)
  );

  exec_unit u_exec_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .empty        (empty),
    .head         (head),
    .pop          (pop),
    .retire       (retire),
    .retire_state (retire_state),
    .idle         (exec_idle)
  );

  // Finished once every word has been issued, drained and executed
  assign done = issued_all && empty && exec_idle;

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`default_nettype none

module exec_unit import nib_cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     empty,
  input  fetched_t head,
  output logic     pop,
  output logic     retire,
  output retire_t  retire_state,
  output logic     idle
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_MODIFY,
    ST_WRITE
  } state_e;

  state_e           state_q;
  state_e           state_nxt;
  fetched_t         ir_q;        // Instruction currently in execute
  logic [NIB_W-1:0] ram_q [RAM_WORDS];
  logic [NIB_W-1:0] sp_q;
  logic             carry_q;
  logic             zero_q;
  logic [NIB_W-1:0] operand_q;   // RAM value picked up in the read step
  logic [NIB_W-1:0] result_q;
  logic             cout_q;      // Carry out of INC, borrow out of DEC
  logic [NIB_W:0]   sum;
  logic             ir_inc_m;
  logic             ir_dec_m;
  logic             ir_mem;
  logic             ir_inc_sp;
  logic             ir_dec_sp;
  logic             ir_sti;
  logic             ram_we;
  logic [NIB_W-1:0] ram_addr;
  logic [NIB_W-1:0] ram_wdata;
  logic [NIB_W-1:0] sp_nxt;
  logic             carry_nxt;
  logic             zero_nxt;

  function automatic logic is_mem_form(instr_u w);
    return (w.mem.op == OP_INC_M) || (w.mem.op == OP_DEC_M);
  endfunction

  // Decode of the held word through both views of the union
  assign ir_inc_m  = (ir_q.word.mem.op == OP_INC_M);
  assign ir_dec_m  = (ir_q.word.mem.op == OP_DEC_M);
  assign ir_mem    = ir_inc_m || ir_dec_m;
  assign ir_inc_sp = (ir_q.word == OP_INC_SP);
  assign ir_dec_sp = (ir_q.word == OP_DEC_SP);
  assign ir_sti    = (ir_q.word.imm.op == OP_STI);

  // A new word is taken when execute is free or finishing this cycle
  assign pop    = !empty && (state_q == ST_IDLE || state_q == ST_WRITE);
  assign retire = (state_q == ST_WRITE);
  assign idle   = (state_q == ST_IDLE);

  always_comb begin
    case (state_q)
      ST_READ:   state_nxt = ST_MODIFY;
      ST_MODIFY: state_nxt = ST_WRITE;
      default:   state_nxt = ST_IDLE;
    endcase
    // Memory forms walk read, modify, write; everything else goes straight to write
    if (pop) begin
      state_nxt = is_mem_form(head.word) ? ST_READ : ST_WRITE;
    end
  end

  // Wrapping in five bits leaves the carry or borrow in the top bit
  assign sum = ir_inc_m ? {1'b0, operand_q} + 1'b1 : {1'b0, operand_q} - 1'b1;

  always_ff @(posedge clk) begin
    if (pop) begin
      ir_q <= head;
    end
    if (state_q == ST_READ) begin
      operand_q <= ram_q[ir_q.word.mem.addr];
    end
    if (state_q == ST_MODIFY) begin
      {cout_q, result_q} <= sum;
    end
  end

  // Write-back values, also what the retire report shows
  assign ram_we    = retire && (ir_mem || ir_sti);
  assign ram_addr  = !ram_we ? '0 : ir_sti ? ir_q.word.imm.addr : ir_q.word.mem.addr;
  assign ram_wdata = !ram_we ? '0 : ir_sti ? ir_q.word.imm.data : result_q;

  always_comb begin
    sp_nxt = sp_q; // SP wraps modulo 16
    if (ir_inc_sp) begin
      sp_nxt = sp_q + 1'b1;
    end else if (ir_dec_sp) begin
      sp_nxt = sp_q - 1'b1;
    end
  end

  assign carry_nxt = ir_mem ? cout_q : carry_q;
  assign zero_nxt  = ir_mem ? (result_q == '0) : zero_q; // Only INC/DEC Mn touch flags

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      sp_q    <= '0;
      carry_q <= 1'b0;
      zero_q  <= 1'b0;
      for (int i = 0; i < RAM_WORDS; i++) begin
        ram_q[i] <= '0;
      end
    end else begin
      state_q <= state_nxt;
      if (retire) begin
        sp_q    <= sp_nxt;
        carry_q <= carry_nxt;
        zero_q  <= zero_nxt;
      end
      if (ram_we) begin
        ram_q[ram_addr] <= ram_wdata;
      end
    end
  end

  always_comb begin
    retire_state.pc       = ir_q.pc;
    retire_state.ram_we   = ram_we;
    retire_state.ram_addr = ram_addr;
    retire_state.ram_data = ram_wdata;
    retire_state.sp       = sp_nxt;
    retire_state.carry    = carry_nxt;
    retire_state.zero     = zero_nxt;
  end

  // A memory form needs its read and modify steps, so it cannot retire back to back
  a_mem_not_back_to_back: assert property (
    @(posedge clk) disable iff (!rst_n)
    (retire && ir_mem) |-> !$past(retire)
  ) else $error("memory-form instruction retired on consecutive cycles");

endmodule

`default_nettype wire

/* src/instr_queue.sv */
`default_nettype none

module instr_queue import nib_cpu_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  fetched_t wr_item,
  input  logic     pop,
  output fetched_t rd_item,
  output logic     full,
  output logic     empty
);

  localparam int AW = $clog2(QUEUE_DEPTH);

  fetched_t      entries [QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q; // One bit wider than the pointers so full is distinct from empty

  // Storage only, the pointers decide what is valid
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr_q] <= wr_item;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Both or neither leave occupancy unchanged
      endcase
    end
  end

  assign rd_item = entries[rd_ptr_q]; // Head is visible the cycle after its push
  assign full    = (count_q == QUEUE_DEPTH);
  assign empty   = (count_q == '0);

  initial begin
    assert (QUEUE_DEPTH >= 2 && (QUEUE_DEPTH & (QUEUE_DEPTH - 1)) == 0)
      else $error("QUEUE_DEPTH must be a power of two, at least 2");
  end

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    empty |-> !pop
  ) else $error("pop from an empty queue");

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    full |-> !push
  ) else $error("push into a full queue");

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`default_nettype none

module fetch_unit import nib_cpu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            prog_we,
  input  logic [PC_W-1:0] prog_addr,
  input  instr_u          prog_data,
  input  logic [PC_W-1:0] prog_len,
  input  logic            full,
  output logic            push,
  output fetched_t        fetched,
  output logic            issued_all
);

  instr_u          prog_mem [PROG_WORDS];
  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] len_q;
  logic            started_q;
  logic            words_left;

  // Program image is written by the bench while the core is held in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  // The run length is captured during reset and then held for the whole run
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      len_q <= prog_len;
    end
  end

  // Issue starts on the first clock after reset is released
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
    end
  end

  assign words_left = (pc_q != len_q);

  // Fetch is strictly sequential, there are no branches to follow
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (push) begin
      pc_q <= pc_q + 1'b1;
    end
  end

  // Push only while the queue has room, so the PC holds under back-pressure
  assign push       = started_q && words_left && !full;
  assign issued_all = started_q && !words_left;

  assign fetched.pc   = pc_q;
  assign fetched.word = prog_mem[pc_q]; // Asynchronous read keeps issue at one word per cycle

  // The queue is never offered a word it cannot take
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    full |-> !push
  ) else $error("fetch pushed into a full queue");

  // Loading the program while the core runs would race the issue path
  a_load_in_reset: assert property (
    @(posedge clk)
    prog_we |-> !rst_n
  ) else $error("program write outside of reset");

endmodule

`default_nettype wire

/* src/nib_cpu_pkg.sv */
`default_nettype none

package nib_cpu_pkg;

  localparam int PC_W       = 8;          // Program counter and program address width
  localparam int NIB_W      = 4;          // Data path is one nibble wide
  localparam int PROG_WORDS = 1 << PC_W;  // Program memory depth
  localparam int RAM_WORDS  = 1 << NIB_W; // Data RAM depth, addressed by one nibble

  // Register/memory form: INC Mn, DEC Mn, INC SP, DEC SP
  typedef struct packed {
    logic [7:0]       op;
    logic [NIB_W-1:0] addr;
  } mem_form_t;

  // Immediate-store form: STI Mn,#d
  typedef struct packed {
    logic [3:0]       op;
    logic [NIB_W-1:0] addr;
    logic [NIB_W-1:0] data;
  } imm_form_t;

  // One 12-bit instruction word, seen through either decode
  typedef union packed {
    mem_form_t mem;
    imm_form_t imm;
  } instr_u;

  localparam logic [7:0]  OP_INC_M  = 8'hF6;
  localparam logic [7:0]  OP_DEC_M  = 8'hF7;
  localparam logic [11:0] OP_DEC_SP = 12'hFCB; // Matched on the full word
  localparam logic [11:0] OP_INC_SP = 12'hFDB;
  localparam logic [3:0]  OP_STI    = 4'h9;

  // Queue entry: the word together with the address it came from
  typedef struct packed {
    logic [PC_W-1:0] pc;
    instr_u          word;
  } fetched_t;

  // Machine state reported as each instruction retires
  typedef struct packed {
    logic [PC_W-1:0]  pc;
    logic             ram_we;
    logic [NIB_W-1:0] ram_addr;
    logic [NIB_W-1:0] ram_data;
    logic [NIB_W-1:0] sp;
    logic             carry;
    logic             zero;
  } retire_t;

endpackage

`default_nettype wire
